// ==== list.f ====
src/soc_pkg.sv
src/mem_bus_if.sv
src/reg_bus_if.sv
src/cpu_port.sv
src/bus_decoder.sv
src/sram.sv
src/sys_timer.sv
src/irq_ctrl.sv
src/soc_mem_top.sv
bench/tb_soc_mem.sv

// ==== Makefile ====
# Verilator simulation of the memory and interrupt subsystem
# Override any variable on the command line, e.g. make sim SEED_LOG=run.log

TOP             ?= tb_soc_mem
SEED_LOG        ?= sim.log
OBJ_DIR         ?= obj_dir
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing -j 0

.PHONY: sim clean

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f list.f
	-./$(OBJ_DIR)/V$(TOP) > $(SEED_LOG) 2>&1
	@cat $(SEED_LOG)
	@grep -qx "No errors" $(SEED_LOG)

clean:
	rm -rf $(OBJ_DIR) $(SEED_LOG)

// ==== bench/tb_soc_mem.sv ====
// ----------------------------------------
// Directed testbench for the memory subsystem
// RAM strobes, handshake, timer, interrupts
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_soc_mem;

    localparam int RAM_WORDS    = 64;      // Small RAM, fully initialized
    localparam int CLK_HALF     = 10;      // 20 ns period
    localparam int RESET_CYCLES = 10;
    localparam int TIMER_N      = 40;      // Timer reload value
    localparam int RANDOM_OPS   = 400;
    localparam int READY_LIMIT  = 8;       // Per-access wait bound

    // Fill and readback, strobes, unmapped, timer, irq, random traffic
    localparam int PLANNED_ACCESSES = 2 * RAM_WORDS + 30 + 6 + 25 + 10 + RANDOM_OPS;
    localparam int TIMER_WAIT       = TIMER_N + 10;
    localparam int IRQ_WAIT         = 12;  // Fixed waits in the flag test
    localparam int WATCHDOG_CYCLES  =
        2 * (3 * PLANNED_ACCESSES + TIMER_WAIT + IRQ_WAIT + RESET_CYCLES);

    logic              clk;
    logic              reset;
    soc_pkg::mem_fwd_t fwd;
    soc_pkg::mem_ret_t ret;
    logic [31:0]       irq_flags;
    logic [31:0]       irq;

    logic [31:0]       ram_model [RAM_WORDS];  // Expected RAM contents
    int unsigned       cycle_count = 0;
    int unsigned       last_ready_cycle;       // Cycle of the last ready

    soc_mem_top #(
        .RAM_WORDS   (RAM_WORDS),
        .TIMER_WIDTH (32)
    ) soc_mem_top_i (
        .clk            (clk),
        .reset          (reset),
        .mem_packed_fwd (fwd),
        .mem_packed_ret (ret),
        .irq_flags      (irq_flags),
        .irq            (irq)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    // Watchdog
    initial begin
        #(WATCHDOG_CYCLES * 2 * CLK_HALF);
        $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $fatal(1, "watchdog expired");
    end

    // ----------------------------------------
    // Error handling and compare tasks
    // ----------------------------------------
    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_rdata(input string what, input soc_pkg::mem_ret_t got,
                               input logic [31:0] exp);
        if (got.rdata !== exp)
            stop_run($sformatf("CHECK FAILED rdata (%s): got 0x%08h expected 0x%08h",
                               what, got.rdata, exp));
    endtask

    task automatic check_irq(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp)
            stop_run($sformatf("CHECK FAILED irq (%s): got 0x%08h expected 0x%08h",
                               what, got, exp));
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp)
            stop_run($sformatf("CHECK FAILED ready latency: got 0x%0h expected 0x%0h",
                               got, exp));
    endtask

    // ----------------------------------------
    // Bus tasks, called on a falling edge
    // ----------------------------------------
    task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] wstrb, output soc_pkg::mem_ret_t r);
        int cycles;
        cycles    = 0;
        fwd.addr  = addr;
        fwd.wdata = wdata;
        fwd.wstrb = wstrb;
        fwd.valid = 1'b1;
        do begin
            @(negedge clk);
            cycles++;
            if (cycles > READY_LIMIT)
                stop_run("No ready came back for a bus access");
        end while (ret.ready !== 1'b1);
        r                = ret;      // Sampled mid-cycle
        last_ready_cycle = cycle_count;
        fwd.valid        = 1'b0;
        fwd.wstrb        = '0;
        check_latency(cycles, 2);
        @(negedge clk);
        if (ret.ready !== 1'b0)     // One-cycle ready
            stop_run($sformatf("CHECK FAILED ready: got 0x%0h expected 0x0 after response",
                               ret.ready));
    endtask

    task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb);
        soc_pkg::mem_ret_t r;
        bus_access(addr, data, strb, r);
    endtask

    task automatic read_word(input logic [31:0] addr, output soc_pkg::mem_ret_t r);
        bus_access(addr, 32'h0, 4'h0, r);
    endtask

    // Byte-lane merge as the RAM is specified
    function automatic logic [31:0] apply_strobes(input logic [31:0] old,
                                                  input logic [31:0] data,
                                                  input logic [3:0] strb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++)
            if (strb[b])
                res[8*b +: 8] = data[8*b +: 8];
        return res;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [31:0] base, input logic [1:0] offs);
        return base | {28'd0, offs, 2'b00};
    endfunction

    task automatic ram_store(input int idx, input logic [31:0] data, input logic [3:0] strb);
        write_word(32'(idx * 4), data, strb);
        ram_model[idx] = apply_strobes(ram_model[idx], data, strb);
    endtask

    task automatic ram_verify(input int idx);
        soc_pkg::mem_ret_t r;
        read_word(32'(idx * 4), r);
        check_rdata($sformatf("RAM word %0d", idx), r, ram_model[idx]);
    endtask

    // ----------------------------------------
    // Tests
    // ----------------------------------------
    task automatic fill_ram();
        for (int i = 0; i < RAM_WORDS; i++)   // Pattern over the byte address
            ram_store(i, (32'(i * 4) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f, 4'hf);
    endtask

    task automatic test_ram_strobes();
        ram_store(5, 32'h1122_3344, 4'hf);
        ram_verify(5);
        for (int s = 1; s < 15; s++) begin    // Every partial strobe
            ram_store(5, 32'ha5c3_0f96 + 32'(s) * 32'h0101_0101, 4'(s));
            ram_verify(5);
        end
    endtask

    task automatic test_unmapped();
        soc_pkg::mem_ret_t r;
        read_word(32'h8000_0010, r);
        check_rdata("unmapped read", r, 32'h0);
        read_word(32'h3000_0000, r);
        check_rdata("unmapped read", r, 32'h0);
        read_word(32'(RAM_WORDS * 4), r);            // First word past the RAM
        check_rdata("RAM read out of range", r, 32'h0);
        write_word(32'h8000_0010, 32'hffff_ffff, 4'hf);
        write_word(32'(RAM_WORDS * 4), 32'hdead_beef, 4'hf);
        write_word(32'(RAM_WORDS * 4 + 20), 32'hcafe_f00d, 4'hf);  // Would alias word 5
        for (int i = 0; i < RAM_WORDS; i++)
            ram_verify(i);
    endtask

    task automatic test_timer();
        soc_pkg::mem_ret_t r;
        int unsigned       enable_cycle;
        int unsigned       elapsed;
        logic              expired;
        write_word(reg_addr(soc_pkg::TIMER_BASE, soc_pkg::TMR_LOAD), 32'(TIMER_N), 4'hf);
        write_word(reg_addr(soc_pkg::TIMER_BASE, soc_pkg::TMR_CTRL), 32'h1, 4'hf);
        enable_cycle = last_ready_cycle;
        expired      = 1'b0;
        while (!expired) begin
            read_word(reg_addr(soc_pkg::TIMER_BASE, soc_pkg::TMR_STATUS), r);
            elapsed = last_ready_cycle - enable_cycle;
            if (elapsed <= TIMER_N)
                check_rdata("STATUS before expiry", r, 32'h0);
            else if (elapsed > TIMER_N + 10)
                stop_run("Timer STATUS was not set within N+10 cycles of the enable write");
            else if (r.rdata[0] === 1'b1) begin
                check_rdata("STATUS at expiry", r, 32'h1);
                expired = 1'b1;
            end
        end
        write_word(reg_addr(soc_pkg::IRQ_BASE, soc_pkg::IRQ_MASK), 32'h1, 4'hf);
        check_irq("timer unmasked", irq, 32'h1);      // Registered one cycle on
        read_word(reg_addr(soc_pkg::IRQ_BASE, soc_pkg::IRQ_STATE), r);
        check_rdata("IRQ_STATE timer", r, 32'h1);
        write_word(reg_addr(soc_pkg::TIMER_BASE, soc_pkg::TMR_CTRL), 32'h0, 4'hf);  // Stop
        write_word(reg_addr(soc_pkg::TIMER_BASE, soc_pkg::TMR_STATUS), 32'h1, 4'hf);
        check_irq("timer cleared", irq, 32'h0);
        read_word(reg_addr(soc_pkg::TIMER_BASE, soc_pkg::TMR_STATUS), r);
        check_rdata("STATUS after clear", r, 32'h0);
    endtask

    task automatic test_irq_flags();
        soc_pkg::mem_ret_t r;
        write_word(reg_addr(soc_pkg::IRQ_BASE, soc_pkg::IRQ_MASK), 32'h0001_00f0, 4'hf);
        irq_flags = 32'h0000_0ff0;            // Levels 11..4, only 7..4 unmasked
        @(negedge clk);
        check_irq("levels held", irq, 32'h0000_00f0);
        repeat (3) @(negedge clk);
        check_irq("levels still held", irq, 32'h0000_00f0);
        irq_flags = 32'h0;
        @(negedge clk);
        check_irq("levels dropped", irq, 32'h0);
        irq_flags = 32'h0003_0000;            // One-cycle pulse, bit 17 masked
        @(negedge clk);
        irq_flags = 32'h0;
        @(negedge clk);
        check_irq("edge latched", irq, 32'h0001_0000);
        repeat (3) @(negedge clk);
        check_irq("edge still latched", irq, 32'h0001_0000);
        read_word(reg_addr(soc_pkg::IRQ_BASE, soc_pkg::IRQ_PENDING), r);
        check_rdata("IRQ_PENDING", r, 32'h0003_0000);
        read_word(reg_addr(soc_pkg::IRQ_BASE, soc_pkg::IRQ_STATE), r);
        check_rdata("IRQ_STATE", r, 32'h0003_0000);
        write_word(reg_addr(soc_pkg::IRQ_BASE, soc_pkg::IRQ_PENDING), 32'h0001_0000, 4'hf);
        check_irq("pending cleared", irq, 32'h0);
        read_word(reg_addr(soc_pkg::IRQ_BASE, soc_pkg::IRQ_PENDING), r);
        check_rdata("IRQ_PENDING after clear", r, 32'h0002_0000);
        write_word(reg_addr(soc_pkg::IRQ_BASE, soc_pkg::IRQ_PENDING), 32'h0002_0000, 4'hf);
        read_word(reg_addr(soc_pkg::IRQ_BASE, soc_pkg::IRQ_PENDING), r);
        check_rdata("IRQ_PENDING empty", r, 32'h0);
        write_word(reg_addr(soc_pkg::IRQ_BASE, soc_pkg::IRQ_MASK), 32'h0, 4'hf);
    endtask

    task automatic test_random_traffic();
        int idx;
        for (int n = 0; n < RANDOM_OPS; n++) begin
            idx = int'($urandom % RAM_WORDS);
            if ($urandom % 2 == 0)
                ram_verify(idx);
            else
                ram_store(idx, $urandom, 4'($urandom % 15 + 1));  // Never zero
        end
    endtask

    // ----------------------------------------
    // Sequence
    // ----------------------------------------
    initial begin
        reset       = 1'b1;
        fwd         = '0;
        irq_flags   = '0;
        void'($urandom(32'hdb5e_7161));
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_irq("after reset", irq, 32'h0);
        fill_ram();
        test_ram_strobes();
        test_unmapped();
        test_timer();
        test_irq_flags();
        test_random_traffic();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== src/soc_mem_top.sv ====
// ----------------------------------------
// Memory and interrupt subsystem top
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module soc_mem_top #(
    parameter int RAM_WORDS   = 1024,
    parameter int TIMER_WIDTH = 32
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire soc_pkg::mem_fwd_t mem_packed_fwd,  // Core to decoder
    output soc_pkg::mem_ret_t      mem_packed_ret,  // Decoder to core
    input  wire  [31:0]            irq_flags,
    output logic [31:0]            irq
);

    logic [31:0] irq_level;
    logic [31:0] irq_rise;
    logic        timer_irq;

    mem_bus_if cpu_bus ();
    reg_bus_if ram_bus ();
    reg_bus_if tmr_bus ();
    reg_bus_if irq_bus ();

    // ----------------------------------------
    // Core side
    // ----------------------------------------
    cpu_port cpu_port_i (
        .clk       (clk),
        .reset     (reset),
        .fwd       (mem_packed_fwd),
        .ret       (mem_packed_ret),
        .bus       (cpu_bus.cpu),
        .irq_flags (irq_flags),
        .irq_level (irq_level),
        .irq_rise  (irq_rise)
    );

    bus_decoder #(
        .RAM_WORDS (RAM_WORDS)
    ) bus_decoder_i (
        .clk   (clk),
        .reset (reset),
        .bus   (cpu_bus.fabric),
        .ram   (ram_bus.host),
        .tmr   (tmr_bus.host),
        .irqc  (irq_bus.host)
    );

    // ----------------------------------------
    // Targets
    // ----------------------------------------
    sram #(
        .RAM_WORDS (RAM_WORDS)
    ) sram_i (
        .clk  (clk),
        .port (ram_bus.target)
    );

    sys_timer #(
        .TIMER_WIDTH (TIMER_WIDTH)
    ) sys_timer_i (
        .clk       (clk),
        .reset     (reset),
        .port      (tmr_bus.target),
        .timer_irq (timer_irq)
    );

    irq_ctrl irq_ctrl_i (
        .clk       (clk),
        .reset     (reset),
        .port      (irq_bus.target),
        .irq_level (irq_level),
        .irq_rise  (irq_rise),
        .timer_irq (timer_irq),
        .irq       (irq)
    );

endmodule

`default_nettype wire

// ==== src/irq_ctrl.sv ====
// ----------------------------------------
// Interrupt controller
// Pending latch, mask, merged vector
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl (
    input  wire         clk,
    input  wire         reset,
    reg_bus_if.target   port,
    input  wire  [31:0] irq_level,
    input  wire  [31:0] irq_rise,
    input  wire         timer_irq,
    output logic [31:0] irq
);

    logic [31:0] pending_q;     // Latched edge requests
    logic [31:0] mask_q;        // 1 enables the bit
    logic [31:0] clr;           // Write-1-to-clear lanes
    logic [31:0] timer_vec;
    logic [31:0] merged;        // Request before masking
    logic        wr;

    assign wr  = port.sel && port.we;
    assign clr = (wr && port.word_addr[1:0] == soc_pkg::IRQ_PENDING) ? port.wdata : '0;

    // ----------------------------------------
    // Merge
    // ----------------------------------------
    assign timer_vec = {31'd0, timer_irq} << soc_pkg::TIMER_IRQ_BIT;
    assign merged    = pending_q
                     | (irq_level & soc_pkg::LEVEL_IRQ_MASK)
                     | timer_vec;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending_q <= '0;
            mask_q    <= '0;
            irq       <= '0;
        end else begin
            // New edge beats a clear in the same cycle
            pending_q <= (pending_q & ~clr) | (irq_rise & ~soc_pkg::LEVEL_IRQ_MASK);
            if (wr && port.word_addr[1:0] == soc_pkg::IRQ_MASK)
                mask_q <= port.wdata;
            irq <= merged & mask_q;     // One cycle behind inputs
        end
    end

    // Registered read
    always_ff @(posedge clk) begin
        if (port.sel) begin
            case (port.word_addr[1:0])
                soc_pkg::IRQ_PENDING: port.rdata <= pending_q;
                soc_pkg::IRQ_MASK:    port.rdata <= mask_q;
                soc_pkg::IRQ_STATE:   port.rdata <= merged;
                default:              port.rdata <= '0;   // Unused offset
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/sys_timer.sv ====
// ----------------------------------------
// Reloading countdown timer
// LOAD, VALUE, CTRL and STATUS registers
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sys_timer #(
    parameter int TIMER_WIDTH = 32
) (
    input  wire        clk,
    input  wire        reset,
    reg_bus_if.target  port,
    output logic       timer_irq
);

    logic [TIMER_WIDTH-1:0] load_q;     // Reload value
    logic [TIMER_WIDTH-1:0] value_q;    // Current count
    logic                   run_q;      // CTRL bit 0
    logic                   expired_q;  // STATUS bit 0, sticky
    logic                   wr;
    logic [1:0]             offs;

    assign offs = port.word_addr[1:0];
    assign wr   = port.sel && port.we;

    // ----------------------------------------
    // Counter and registers
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            load_q    <= '0;
            value_q   <= '0;
            run_q     <= 1'b0;
            expired_q <= 1'b0;
        end else begin
            // Software clear first, expiry below wins
            if (wr && offs == soc_pkg::TMR_STATUS && port.wdata[0])
                expired_q <= 1'b0;

            if (run_q) begin
                if (value_q == '0) begin
                    value_q   <= load_q;    // Reload and flag
                    expired_q <= 1'b1;
                end else begin
                    value_q <= value_q - 1'b1;
                end
            end

            if (wr && offs == soc_pkg::TMR_LOAD)
                load_q <= port.wdata[TIMER_WIDTH-1:0];

            if (wr && offs == soc_pkg::TMR_CTRL) begin
                run_q <= port.wdata[0];
                if (port.wdata[0])
                    value_q <= load_q;      // Start from LOAD
            end
        end
    end

    // Registered read
    always_ff @(posedge clk) begin
        if (port.sel) begin
            case (offs)
                soc_pkg::TMR_LOAD:  port.rdata <= 32'(load_q);
                soc_pkg::TMR_VALUE: port.rdata <= 32'(value_q);
                soc_pkg::TMR_CTRL:  port.rdata <= {31'd0, run_q};
                default:            port.rdata <= {31'd0, expired_q};
            endcase
        end
    end

    assign timer_irq = expired_q;

endmodule

`default_nettype wire

// ==== src/sram.sv ====
// ----------------------------------------
// Word RAM with byte write strobes
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sram #(
    parameter int RAM_WORDS = 1024
) (
    input  wire        clk,
    reg_bus_if.target  port
);

    localparam int AW = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

    logic [31:0]   mem [RAM_WORDS];
    logic [AW-1:0] idx;

    // Decoder only selects in-range words
    assign idx = port.word_addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (port.sel) begin
            if (port.we) begin
                // Only strobed lanes change
                for (int b = 0; b < 4; b++) begin
                    if (port.wstrb[b])
                        mem[idx][8*b +: 8] <= port.wdata[8*b +: 8];
                end
            end
            port.rdata <= mem[idx];     // Old word on a write
        end
    end

endmodule

`default_nettype wire

// ==== src/bus_decoder.sv ====
// ----------------------------------------
// Bus decoder FSM
// Region select, target strobe, response
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bus_decoder #(
    parameter int RAM_WORDS = 1024
) (
    input  wire        clk,
    input  wire        reset,
    mem_bus_if.fabric  bus,
    reg_bus_if.host    ram,
    reg_bus_if.host    tmr,
    reg_bus_if.host    irqc
);

    soc_pkg::dec_state_t state_q;
    soc_pkg::region_t    region_d;
    soc_pkg::region_t    region_q;     // Target of the current access
    logic [31:0]         word_idx;     // Word index, zero extended
    logic                access;

    // ----------------------------------------
    // Region decode
    // ----------------------------------------
    assign word_idx = {{(32 - soc_pkg::WORD_AW){1'b0}}, bus.addr[soc_pkg::WORD_AW+1:2]};

    always_comb begin
        region_d = soc_pkg::REGION_NONE;
        if (bus.addr[31:28] == soc_pkg::RAM_BASE[31:28]) begin
            if (word_idx < RAM_WORDS)
                region_d = soc_pkg::REGION_RAM;     // Out of range stays NONE
        end else if (bus.addr[31:28] == soc_pkg::TIMER_BASE[31:28]) begin
            if (bus.addr[8] == soc_pkg::TIMER_BASE[8])
                region_d = soc_pkg::REGION_TIMER;
            else if (bus.addr[8] == soc_pkg::IRQ_BASE[8])
                region_d = soc_pkg::REGION_IRQ;
        end
    end

    // ----------------------------------------
    // Sequencer
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state_q  <= soc_pkg::IDLE;
            region_q <= soc_pkg::REGION_NONE;
        end else begin
            case (state_q)
                soc_pkg::IDLE: begin
                    if (bus.valid) begin
                        state_q  <= soc_pkg::ACCESS;
                        region_q <= region_d;       // Latch target at start
                    end
                end
                soc_pkg::ACCESS:  state_q <= soc_pkg::RESPOND;
                default:          state_q <= soc_pkg::IDLE;
            endcase
        end
    end

    assign access = (state_q == soc_pkg::ACCESS);

    // Shared request fields, only sel differs per target
    assign ram.sel        = access && (region_q == soc_pkg::REGION_RAM);
    assign tmr.sel        = access && (region_q == soc_pkg::REGION_TIMER);
    assign irqc.sel       = access && (region_q == soc_pkg::REGION_IRQ);
    assign ram.we         = |bus.wstrb;
    assign tmr.we         = |bus.wstrb;
    assign irqc.we        = |bus.wstrb;
    assign ram.word_addr  = bus.addr[soc_pkg::WORD_AW+1:2];
    assign tmr.word_addr  = bus.addr[soc_pkg::WORD_AW+1:2];
    assign irqc.word_addr = bus.addr[soc_pkg::WORD_AW+1:2];
    assign ram.wdata      = bus.wdata;
    assign tmr.wdata      = bus.wdata;
    assign irqc.wdata     = bus.wdata;
    assign ram.wstrb      = bus.wstrb;
    assign tmr.wstrb      = bus.wstrb;
    assign irqc.wstrb     = bus.wstrb;

    // ----------------------------------------
    // Response
    // ----------------------------------------
    assign bus.ready = (state_q == soc_pkg::RESPOND);

    always_comb begin
        bus.rdata = '0;
        if (state_q == soc_pkg::RESPOND) begin
            case (region_q)
                soc_pkg::REGION_RAM:   bus.rdata = ram.rdata;
                soc_pkg::REGION_TIMER: bus.rdata = tmr.rdata;
                soc_pkg::REGION_IRQ:   bus.rdata = irqc.rdata;
                default:               bus.rdata = '0;     // Unmapped reads zero
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== src/cpu_port.sv ====
// ----------------------------------------
// Core port, packed bus to native bus
// Interrupt flag edge conditioning
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cpu_port (
    input  wire                clk,
    input  wire                reset,
    input  wire soc_pkg::mem_fwd_t fwd,     // From core
    output soc_pkg::mem_ret_t  ret,         // To core
    mem_bus_if.cpu             bus,
    input  wire  [31:0]        irq_flags,
    output logic [31:0]        irq_level,
    output logic [31:0]        irq_rise
);

    logic [31:0] flags_q;   // Flags one cycle ago

    // ----------------------------------------
    // Bus unpack and pack
    // ----------------------------------------
    assign bus.valid = fwd.valid;
    assign bus.addr  = fwd.addr;
    assign bus.wdata = fwd.wdata;
    assign bus.wstrb = fwd.wstrb;

    assign ret.rdata = bus.rdata;
    assign ret.ready = bus.ready;

    // ----------------------------------------
    // Interrupt flags
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            flags_q <= '0;
        end else begin
            flags_q <= irq_flags;
        end
    end

    // Lower half passes straight through as levels
    assign irq_level = irq_flags & soc_pkg::LEVEL_IRQ_MASK;

    // Upper half, high now and low last cycle
    assign irq_rise = irq_flags & ~flags_q & ~soc_pkg::LEVEL_IRQ_MASK;

endmodule

`default_nettype wire

// ==== src/reg_bus_if.sv ====
// ----------------------------------------
// Decoder to target register bus
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;

    logic                         sel;        // One-cycle strobe
    logic                         we;         // Write in the sel cycle
    logic [soc_pkg::WORD_AW-1:0]  word_addr;  // Word index in region
    logic [31:0]                  wdata;
    logic [3:0]                   wstrb;
    logic [31:0]                  rdata;      // Registered by target

    modport host (
        output sel,
        output we,
        output word_addr,
        output wdata,
        output wstrb,
        input  rdata
    );

    modport target (
        input  sel,
        input  we,
        input  word_addr,
        input  wdata,
        input  wstrb,
        output rdata
    );

endinterface

`default_nettype wire

// ==== src/mem_bus_if.sv ====
// ----------------------------------------
// Native valid/ready memory bus
// Core side and fabric side modports
// ----------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if;

    logic        valid;     // Held until ready is seen
    logic        ready;     // High one cycle per access
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;     // Nonzero means write
    logic [31:0] rdata;

    // Request side, fed from the core bus
    modport cpu (
        output valid,
        output addr,
        output wdata,
        output wstrb,
        input  ready,
        input  rdata
    );

    // Response side, the decoder
    modport fabric (
        input  valid,
        input  addr,
        input  wdata,
        input  wstrb,
        output ready,
        output rdata
    );

endinterface

`default_nettype wire

// ==== src/soc_pkg.sv ====
// ----------------------------------------
// Shared package for the memory subsystem
// Packed core bus structs, address map,
// register offsets and decoder states
// ----------------------------------------
`default_nettype none

package soc_pkg;

    // ----------------------------------------
    // Core bus, packed as the core drives it
    // ----------------------------------------
    typedef struct packed {
        logic [31:0] wdata;     // Write data
        logic [3:0]  wstrb;     // Byte lanes, zero for a read
        logic        valid;     // Access request
        logic [31:0] addr;      // Byte address
    } mem_fwd_t;                // 69 bits

    typedef struct packed {
        logic [31:0] rdata;     // Read data
        logic        ready;     // One-cycle completion
    } mem_ret_t;                // 33 bits

    // ----------------------------------------
    // Address map
    // ----------------------------------------
    localparam logic [31:0] RAM_BASE   = 32'h0000_0000;
    localparam logic [31:0] TIMER_BASE = 32'h1000_0000;
    localparam logic [31:0] IRQ_BASE   = 32'h1000_0100;

    // Word index inside a region, byte address bits 27..2
    localparam int WORD_AW = 26;

    typedef enum logic [1:0] {
        REGION_RAM   = 2'd0,
        REGION_TIMER = 2'd1,
        REGION_IRQ   = 2'd2,
        REGION_NONE  = 2'd3
    } region_t;

    // Timer register word offsets
    localparam logic [1:0] TMR_LOAD   = 2'd0;
    localparam logic [1:0] TMR_VALUE  = 2'd1;
    localparam logic [1:0] TMR_CTRL   = 2'd2;
    localparam logic [1:0] TMR_STATUS = 2'd3;

    // Interrupt controller word offsets
    localparam logic [1:0] IRQ_PENDING = 2'd0;
    localparam logic [1:0] IRQ_MASK    = 2'd1;
    localparam logic [1:0] IRQ_STATE   = 2'd2;

    localparam logic [31:0] LEVEL_IRQ_MASK = 32'h0000_FFFF;  // Flags 15..0 are levels
    localparam int          TIMER_IRQ_BIT  = 0;              // Timer joins the vector here

    // Decoder sequencer
    typedef enum logic [1:0] {
        IDLE    = 2'd0,
        ACCESS  = 2'd1,
        RESPOND = 2'd2
    } dec_state_t;

endpackage

`default_nettype wire
